// File: bench/box_filter_assertions.sv
`timescale 1ns/1ps

module box_filter_assertions (
  input logic           clk,
  input logic           rst_n,
  input box_pkg::ctrl_t ctrl_i,
  input logic           finish_i,
  input logic [2:0]     state_i
);

  localparam logic [2:0] IDLE_ENC = 3'd0;  // controller idle encoding.

  // a row load never overlaps the sliding update.
  ld_cum_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(ctrl_i.ld_en && ctrl_i.cum_en))
    else $error("ld_en and cum_en are high in the same cycle");

  finish_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    finish_i |=> !finish_i)
    else $error("finish pulse lasts more than one cycle");

  // the registered valid follows data_valid by one cycle.
  no_valid_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == IDLE_ENC) |-> (!ctrl_i.data_valid && !$past(ctrl_i.data_valid)))
    else $error("valid raised while the controller is idle");

endmodule

bind r2_controller box_filter_assertions box_filter_assertions_inst (
  .clk      (clk),
  .rst_n    (rst_n),
  .ctrl_i   (ctrl_o),
  .finish_i (finish_o),
  .state_i  (state_q)
);

// File: bench/box_filter_tb.sv
`timescale 1ns/1ps

module box_filter_tb;
  import box_pkg::*;

  localparam int ADDR_W    = 18;
  localparam int MEM_DEPTH = 1 << ADDR_W;
  localparam int WIN       = 5;

  logic              clk;
  logic              rst_n;
  logic              start_i;
  size_t             img_size_i;
  pixel_t            pix_data;
  logic [ADDR_W-1:0] pix_addr;
  sum_t              sum_o;
  logic              valid_o;
  logic              finish_o;

  pixel_t      img_mem [0:MEM_DEPTH-1];
  logic [31:0] rng_state;
  int          cur_size;
  int          exp_row;
  int          exp_col;
  int          run_len;
  int          total_cnt;
  int          finish_cnt;

  box_filter_top #(
    .ADDR_W (ADDR_W)
  ) box_filter_top_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (start_i),
    .img_size_i (img_size_i),
    .pix_data_i (pix_data),
    .pix_addr_o (pix_addr),
    .sum_o      (sum_o),
    .valid_o    (valid_o),
    .finish_o   (finish_o)
  );

  assign pix_data = img_mem[pix_addr];  // zero-latency read port.

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // sum of five row pixels from col onward.
  function automatic sum_t ref_sum(input int row, input int col);
    sum_t acc;
    int   i;
    acc = '0;
    for (i = 0; i < WIN; i++) begin
      acc = acc + sum_t'(img_mem[ADDR_W'(row * cur_size + col + i)]);
    end
    return acc;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_sum(input sum_t got, input sum_t exp, input int row, input int col);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] time %0t: sum at row %0d col %0d is %0d, expected %0d",
                         $time, row, col, got, exp));
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      stop_run($sformatf("[ERROR] time %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic expect_low(input logic v, input string what);
    if (v !== 1'b0) begin
      stop_run($sformatf("[ERROR] time %0t: %s is not low", $time, what));
    end
  endtask

  task automatic clear_mem();
    int i;
    for (i = 0; i < MEM_DEPTH; i++) begin
      img_mem[ADDR_W'(i)] = '0;
    end
  endtask

  task automatic fill_random(input int n);
    int i;
    for (i = 0; i < n * n; i++) begin
      rng_state           = xorshift32(rng_state);
      img_mem[ADDR_W'(i)] = rng_state[7:0];
    end
  endtask

  task automatic fill_const(input int n, input pixel_t v);
    int i;
    for (i = 0; i < n * n; i++) begin
      img_mem[ADDR_W'(i)] = v;
    end
  endtask

  task automatic wait_finish(input int limit);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < limit) begin
      @(negedge clk);
      seen   = finish_o;
      cycles = cycles + 1;
    end
    if (!seen) begin
      stop_run($sformatf("timeout: no finish pulse within %0d cycles after start", limit));
    end
  endtask

  task automatic run_image(input int n);
    int fin_before;
    fin_before = finish_cnt;
    @(posedge clk);
    #2;
    cur_size   = n;
    img_size_i = size_t'(n);
    start_i    = 1'b1;
    @(posedge clk);
    #2;
    start_i = 1'b0;
    wait_finish(2 * n * n + 100);
    repeat (3) @(posedge clk);  // room for a stray second pulse.
    check_count(finish_cnt - fin_before, 1, "finish pulses for one image");
  endtask

  // each row arrives as one unbroken run.
  always @(negedge clk) begin
    if (rst_n) begin
      if (valid_o) begin
        check_sum(sum_o, ref_sum(exp_row, exp_col), exp_row, exp_col);
        exp_col   = exp_col + 1;
        run_len   = run_len + 1;
        total_cnt = total_cnt + 1;
        if (exp_col == cur_size - (WIN - 1)) begin
          exp_col = 0;
          exp_row = exp_row + 1;
        end
      end else if (run_len != 0) begin
        check_count(run_len, cur_size - (WIN - 1), "results in one row");
        run_len = 0;
      end
      if (finish_o) begin
        check_count(total_cnt, cur_size * (cur_size - (WIN - 1)), "results in one image");
        finish_cnt = finish_cnt + 1;
        total_cnt  = 0;
        exp_row    = 0;
        exp_col    = 0;
      end
    end
  end

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    start_i    = 1'b0;
    img_size_i = '0;
    rng_state  = 32'hdd62;
    cur_size   = 8;
    exp_row    = 0;
    exp_col    = 0;
    run_len    = 0;
    total_cnt  = 0;
    finish_cnt = 0;
    clear_mem();
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    repeat (20) begin
      @(negedge clk);
      expect_low(valid_o, "valid_o before start");
      expect_low(finish_o, "finish_o before start");
    end
    fill_random(8);
    run_image(8);
    fill_const(8, 8'd255);  // every window sums to 1275.
    run_image(8);
    fill_const(8, 8'd0);
    run_image(8);
    fill_random(13);
    run_image(13);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the box filter testbench with Verilator and runs it.
# The exit status is the simulator's own status.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module box_filter_tb \
  -Mdir obj_dir \
  -f sim.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit "$build_status"
fi

./obj_dir/Vbox_filter_tb
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "simulation failed with status $sim_status"
  exit "$sim_status"
fi

echo "simulation finished with status 0"
exit 0

// File: sim.f
verilog/box_pkg.sv
verilog/box_cfg_regs.sv
verilog/r2_controller.sv
verilog/scan_counter.sv
verilog/window_accumulator.sv
verilog/box_filter_top.sv
bench/box_filter_assertions.sv
bench/box_filter_tb.sv

// File: verilog/box_cfg_regs.sv
`timescale 1ns/1ps

module box_cfg_regs (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start_i,
  input  logic           start_en_i,
  input  box_pkg::size_t img_size_i,
  output box_pkg::cfg_t  cfg_o
);
  import box_pkg::*;

  size_t      img_size_q;
  logic [1:0] start_cnt_q;

  // image side length, held for the whole frame.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      img_size_q <= '0;
    end else if (start_i) begin
      img_size_q <= img_size_i;
    end
  end

  // cycles spent in the start state.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start_cnt_q <= '0;
    end else if (!start_en_i) begin
      start_cnt_q <= '0;
    end else if (start_cnt_q != 2'd3) begin
      start_cnt_q <= start_cnt_q + 2'd1;  // saturate.
    end
  end

  assign cfg_o.img_size   = img_size_q;
  assign cfg_o.start_gt_1 = start_en_i & (start_cnt_q != 2'd0);  // second start cycle.

endmodule

// File: verilog/box_filter_top.sv
`timescale 1ns/1ps

module box_filter_top #(
  parameter int ADDR_W = 18
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_i,
  input  box_pkg::size_t    img_size_i,
  input  box_pkg::pixel_t   pix_data_i,
  output logic [ADDR_W-1:0] pix_addr_o,
  output box_pkg::sum_t     sum_o,
  output logic              valid_o,
  output logic              finish_o
);
  import box_pkg::*;

  cfg_t  cfg;
  ctrl_t ctrl;
  scan_t scan;

  box_cfg_regs box_cfg_regs_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (start_i),
    .start_en_i (ctrl.start_en),
    .img_size_i (img_size_i),
    .cfg_o      (cfg)
  );

  r2_controller r2_controller_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (start_i),
    .cfg_i    (cfg),
    .scan_i   (scan),
    .ctrl_o   (ctrl),
    .finish_o (finish_o)
  );

  scan_counter #(
    .ADDR_W (ADDR_W)
  ) scan_counter_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg_i      (cfg),
    .ctrl_i     (ctrl),
    .scan_o     (scan),
    .pix_addr_o (pix_addr_o)
  );

  window_accumulator window_accumulator_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .ctrl_i  (ctrl),
    .pix_i   (pix_data_i),
    .sum_o   (sum_o),
    .valid_o (valid_o)
  );

endmodule

// File: verilog/box_pkg.sv
package box_pkg;

  localparam int PIX_W  = 8;
  localparam int SIZE_W = 9;

  typedef logic [PIX_W-1:0]  pixel_t;
  typedef logic [PIX_W+2:0]  sum_t;  // room for five full-scale pixels.
  typedef logic [SIZE_W-1:0] size_t;

  typedef struct packed {
    size_t img_size;
    logic  start_gt_1;
  } cfg_t;

  typedef struct packed {
    logic count_en;
    logic ld_en;
    logic sum_en;
    logic cum_en;
    logic start_en;
    logic reset_en;
    logic data_valid;
  } ctrl_t;

  typedef struct packed {
    logic [9:0] col;
    logic       row_eq_max;
    logic       row_done;
  } scan_t;

endpackage

// File: verilog/r2_controller.sv
`timescale 1ns/1ps

module r2_controller (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start_i,
  input  box_pkg::cfg_t  cfg_i,
  input  box_pkg::scan_t scan_i,
  output box_pkg::ctrl_t ctrl_o,
  output logic           finish_o
);
  import box_pkg::*;

  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    START      = 3'd1,
    START_ROW  = 3'd2,
    SUM_EN     = 3'd3,
    CUM_EN     = 3'd4,
    FINISH_ALL = 3'd5
  } state_t;

  state_t state_q;
  state_t prev_q;
  state_t state_d;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
      prev_q  <= IDLE;
    end else begin
      state_q <= state_d;
      prev_q  <= state_q;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:       state_d = start_i ? START : IDLE;
      START:      state_d = cfg_i.start_gt_1 ? START_ROW : START;
      START_ROW:  state_d = SUM_EN;
      SUM_EN: begin
        if (scan_i.row_eq_max) begin
          state_d = FINISH_ALL;  // all rows consumed.
        end else if (scan_i.col > 10'd3) begin
          state_d = CUM_EN;
        end
      end
      CUM_EN:     state_d = scan_i.row_done ? START_ROW : CUM_EN;
      FINISH_ALL: state_d = IDLE;
      default:    state_d = IDLE;
    endcase
  end

  always_comb begin
    ctrl_o   = '0;
    finish_o = 1'b0;
    case (state_q)
      START: begin
        ctrl_o.start_en = 1'b1;
      end
      START_ROW: begin
        ctrl_o.count_en   = 1'b1;
        ctrl_o.ld_en      = 1'b1;
        ctrl_o.data_valid = (prev_q == CUM_EN);  // last window of the row before.
      end
      SUM_EN: begin
        ctrl_o.count_en = 1'b1;
        ctrl_o.sum_en   = 1'b1;
      end
      CUM_EN: begin
        ctrl_o.count_en   = 1'b1;
        ctrl_o.sum_en     = 1'b1;
        ctrl_o.cum_en     = 1'b1;
        ctrl_o.data_valid = 1'b1;
      end
      FINISH_ALL: begin
        ctrl_o.reset_en = 1'b1;
        finish_o        = 1'b1;
      end
      default: begin
        ctrl_o   = '0;
        finish_o = 1'b0;
      end
    endcase
  end

endmodule

// File: verilog/scan_counter.sv
`timescale 1ns/1ps

module scan_counter #(
  parameter int ADDR_W = 18
) (
  input  logic              clk,
  input  logic              rst_n,
  input  box_pkg::cfg_t     cfg_i,
  input  box_pkg::ctrl_t    ctrl_i,
  output box_pkg::scan_t    scan_o,
  output logic [ADDR_W-1:0] pix_addr_o
);
  import box_pkg::*;

  logic [9:0]        col_q;
  logic [9:0]        col_cur;
  logic [9:0]        col_limit;
  size_t             row_q;
  logic [ADDR_W-1:0] row_base_q;

  assign col_cur   = ctrl_i.ld_en ? 10'd0 : col_q;  // a new row starts at column 0.
  assign col_limit = {1'b0, cfg_i.img_size} - 10'd2;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q      <= '0;
      row_q      <= '0;
      row_base_q <= '0;
    end else if (ctrl_i.reset_en) begin
      col_q      <= '0;
      row_q      <= '0;
      row_base_q <= '0;
    end else if (ctrl_i.count_en) begin
      col_q <= col_cur + 10'd1;
      if (ctrl_i.cum_en && scan_o.row_done) begin
        row_q      <= row_q + SIZE_W'(1);
        row_base_q <= row_base_q + ADDR_W'(cfg_i.img_size);  // next row offset.
      end
    end
  end

  assign scan_o.col        = col_cur;
  assign scan_o.row_done   = (col_cur > col_limit);
  assign scan_o.row_eq_max = (row_q == cfg_i.img_size);
  assign pix_addr_o        = row_base_q + ADDR_W'(col_cur);

endmodule

// File: verilog/window_accumulator.sv
`timescale 1ns/1ps

module window_accumulator (
  input  logic            clk,
  input  logic            rst_n,
  input  box_pkg::ctrl_t  ctrl_i,
  input  box_pkg::pixel_t pix_i,
  output box_pkg::sum_t   sum_o,
  output logic            valid_o
);
  import box_pkg::*;

  localparam int DEPTH = 5;

  pixel_t [DEPTH-1:0] hist_q;
  sum_t               win_sum_q;
  sum_t               pix_ext;
  sum_t               old_ext;

  assign pix_ext = sum_t'(pix_i);
  assign old_ext = sum_t'(hist_q[DEPTH-1]);  // pixel leaving the window.

  // history of the last five pixels read.
  always_ff @(posedge clk) begin
    if (ctrl_i.count_en) begin
      hist_q <= {hist_q[DEPTH-2:0], pix_i};
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_i.ld_en) begin
      win_sum_q <= pix_ext;
    end else if (ctrl_i.sum_en && ctrl_i.cum_en) begin
      win_sum_q <= win_sum_q + pix_ext - old_ext;  // slide by one.
    end else if (ctrl_i.sum_en) begin
      win_sum_q <= win_sum_q + pix_ext;
    end
  end

  // completed window goes out on the next edge.
  always_ff @(posedge clk) begin
    if (ctrl_i.data_valid) begin
      sum_o <= win_sum_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= ctrl_i.data_valid;
    end
  end

endmodule
